//--- logic/tl_pkg.sv
package tl_pkg;

    localparam int TL_DW = 32;
    localparam int TL_AW = 32;
    localparam int TL_RS = 4;
    localparam int TL_SZ = 4;
    localparam int TL_MW = TL_DW / 8;        // byte lanes per beat

    localparam int SLAVE_COUNT = 2;
    localparam int SLAVE_IW = $clog2(SLAVE_COUNT);

    // window i is [SLAVE_BASE[i], SLAVE_END[i])
    localparam logic [SLAVE_COUNT-1:0][TL_AW-1:0] SLAVE_BASE = {32'h0000_2000, 32'h0000_1000};
    localparam logic [SLAVE_COUNT-1:0][TL_AW-1:0] SLAVE_END = {32'h0000_3000, 32'h0000_2000};

    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW = $clog2(SRAM_WORDS);

    localparam int BEAT_SIZE = 2;            // log2 bytes per beat
    localparam int MAX_GET_SIZE = 4;         // 16 byte burst
    localparam int BURST_CW = MAX_GET_SIZE - BEAT_SIZE;

    localparam logic [2:0] OP_PUT_FULL = 3'd0;
    localparam logic [2:0] OP_PUT_PARTIAL = 3'd1;
    localparam logic [2:0] OP_GET = 3'd4;

    localparam logic [2:0] OP_ACCESS_ACK = 3'd0;
    localparam logic [2:0] OP_ACCESS_ACK_DATA = 3'd1;

    typedef struct packed {
        logic [2:0]       opcode;
        logic [2:0]       param;
        logic [TL_SZ-1:0] size;
        logic [TL_RS-1:0] source;
        logic [TL_AW-1:0] address;
        logic [TL_MW-1:0] mask;
        logic [TL_DW-1:0] data;
        logic             corrupt;
    } tl_a_chan_t;

    typedef struct packed {
        logic [2:0]       opcode;
        logic [1:0]       param;
        logic [TL_SZ-1:0] size;
        logic [TL_RS-1:0] source;
        logic             denied;
        logic [TL_DW-1:0] data;
        logic             corrupt;
    } tl_d_chan_t;

    // beats that follow the first one for a given size
    function automatic logic [BURST_CW-1:0] burst_beats(input logic [TL_SZ-1:0] size);
        logic [BURST_CW-1:0] extra;
        extra = '0;
        if (size > BEAT_SIZE) begin
            extra = BURST_CW'((1 << (size - BEAT_SIZE)) - 1);
        end
        return extra;
    endfunction

endpackage

//--- logic/tl_request_router.sv
`timescale 1ns/100ps

module tl_request_router
    import tl_pkg::*;
(
    input  logic                               tilelink_clock_i,
    input  logic                               tilelink_reset_i,

    input  tl_a_chan_t                         req_i,
    input  logic                               req_valid_i,
    output logic                               stall_o,

    output tl_a_chan_t [SLAVE_COUNT-1:0]       slave_a_o,
    output logic       [SLAVE_COUNT-1:0]       slave_a_valid_o,
    input  logic       [SLAVE_COUNT-1:0]       slave_a_ready_i
);

    logic [SLAVE_COUNT-1:0] select;
    logic [SLAVE_COUNT-1:0] waiting;
    logic                   load;

    always_comb begin
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            select[i] = req_valid_i &&
                        (req_i.address >= SLAVE_BASE[i]) &&
                        (req_i.address < SLAVE_END[i]);
        end
    end

    // slots still holding a request the target has not taken
    assign waiting = slave_a_valid_o & ~slave_a_ready_i;

    // a pending slot anywhere holds off the next request so slots stay one-hot
    assign stall_o = (|(select & ~slave_a_ready_i)) || ((|select) && (|waiting));

    // address outside both windows is dropped
    assign load = (|select) && !stall_o;

    always_ff @(posedge tilelink_clock_i) begin
        if (tilelink_reset_i) begin
            slave_a_valid_o <= '0;
        end else begin
            for (int i = 0; i < SLAVE_COUNT; i++) begin
                if (load && select[i]) begin
                    slave_a_valid_o[i] <= 1'b1;
                end else if (slave_a_ready_i[i]) begin
                    slave_a_valid_o[i] <= 1'b0;  // taken by target
                end
            end
        end
    end

    always_ff @(posedge tilelink_clock_i) begin
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            if (load && select[i]) begin
                slave_a_o[i] <= req_i;
            end
        end
    end

endmodule

//--- logic/tl_response_arbiter.sv
`timescale 1ns/100ps

module tl_response_arbiter
    import tl_pkg::*;
(
    input  logic                               tilelink_clock_i,
    input  logic                               tilelink_reset_i,

    input  tl_d_chan_t [SLAVE_COUNT-1:0]       slave_d_i,
    input  logic       [SLAVE_COUNT-1:0]       slave_d_valid_i,
    output logic       [SLAVE_COUNT-1:0]       slave_d_ready_o,

    output tl_d_chan_t                         master_d_o,
    output logic                               master_d_valid_o,
    input  logic                               master_d_ready_i
);

    logic [SLAVE_COUNT-1:0] block_q;
    logic [SLAVE_COUNT-1:0] lock_sel_q;
    logic                   lock_q;
    logic [BURST_CW-1:0]    beats_left_q;

    logic [SLAVE_IW-1:0]    sel_idx;
    logic                   grant;
    logic [SLAVE_COUNT-1:0] grant_oh;
    logic                   contended;
    logic                   lock_start;
    logic                   lock_end;
    tl_d_chan_t             sel_beat;

    // lowest index wins among the eligible targets
    always_comb begin
        sel_idx = '0;
        grant = 1'b0;
        for (int n = 0; n < SLAVE_COUNT; n++) begin
            if (!grant && master_d_ready_i && slave_d_valid_i[n] &&
                (lock_q ? lock_sel_q[n] : !block_q[n])) begin
                sel_idx = SLAVE_IW'(n);
                grant = 1'b1;
            end
        end
    end

    assign grant_oh = grant ? (SLAVE_COUNT'(1) << sel_idx) : '0;
    assign slave_d_ready_o = grant_oh;
    assign sel_beat = slave_d_i[sel_idx];
    assign contended = |(slave_d_valid_i & ~grant_oh);  // someone else waiting

    // denied responses are always a single beat
    assign lock_start = grant && !lock_q && !sel_beat.denied &&
                        (sel_beat.opcode == OP_ACCESS_ACK_DATA) &&
                        (sel_beat.size > BEAT_SIZE);
    assign lock_end = grant && lock_q && (beats_left_q == BURST_CW'(1));

    always_ff @(posedge tilelink_clock_i) begin
        if (tilelink_reset_i) begin
            block_q <= '0;
            lock_q <= 1'b0;
            lock_sel_q <= '0;
            beats_left_q <= '0;
        end else begin
            // block is frozen while a burst owns the channel
            if (master_d_ready_i && (!lock_q || lock_end)) begin
                block_q <= (grant && contended) ? grant_oh : '0;
            end
            if (lock_start) begin
                lock_q <= 1'b1;
                lock_sel_q <= grant_oh;
                beats_left_q <= burst_beats(sel_beat.size);
            end else if (lock_q && grant) begin
                beats_left_q <= beats_left_q - 1'b1;
                if (lock_end) begin
                    lock_q <= 1'b0;
                end
            end
        end
    end

    // output slot frees whenever master takes the current beat
    always_ff @(posedge tilelink_clock_i) begin
        if (tilelink_reset_i) begin
            master_d_valid_o <= 1'b0;
        end else if (grant) begin
            master_d_valid_o <= 1'b1;
        end else if (master_d_ready_i) begin
            master_d_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge tilelink_clock_i) begin
        if (grant) begin
            master_d_o <= sel_beat;
        end
    end

endmodule

//--- logic/tl_skid_buffer.sv
`timescale 1ns/100ps

module tl_skid_buffer
    import tl_pkg::*;
(
    input  logic       tilelink_clock_i,
    input  logic       tilelink_reset_i,

    input  tl_a_chan_t in_i,
    input  logic       in_valid_i,
    output logic       in_ready_o,

    output tl_a_chan_t out_o,
    output logic       out_valid_o,
    input  logic       stall_i
);

    tl_a_chan_t spare_q;
    logic       spare_valid_q;
    logic       take;
    logic       advance;

    assign in_ready_o = !spare_valid_q;
    assign take = in_valid_i && in_ready_o;
    assign advance = !stall_i || !out_valid_o;  // primary free or being consumed

    always_ff @(posedge tilelink_clock_i) begin
        if (tilelink_reset_i) begin
            out_valid_o <= 1'b0;
            spare_valid_q <= 1'b0;
        end else if (advance) begin
            if (spare_valid_q) begin
                out_valid_o <= 1'b1;         // drain spare first
                spare_valid_q <= 1'b0;
            end else begin
                out_valid_o <= take;
            end
        end else if (take) begin
            spare_valid_q <= 1'b1;           // park during stall
        end
    end

    always_ff @(posedge tilelink_clock_i) begin
        if (advance) begin
            out_o <= spare_valid_q ? spare_q : in_i;
        end
        if (!advance && take) begin
            spare_q <= in_i;
        end
    end

endmodule

//--- logic/tl_sram_slave.sv
`timescale 1ns/100ps

module tl_sram_slave
    import tl_pkg::*;
(
    input  logic       tilelink_clock_i,
    input  logic       tilelink_reset_i,

    input  tl_a_chan_t a_i,
    input  logic       a_valid_i,
    output logic       a_ready_o,

    output tl_d_chan_t d_o,
    output logic       d_valid_o,
    input  logic       d_ready_i
);

    logic [TL_DW-1:0]    mem [SRAM_WORDS];
    logic [SRAM_AW-1:0]  a_idx;
    logic [SRAM_AW-1:0]  next_idx_q;
    logic [BURST_CW-1:0] beats_left_q;
    logic                accept;
    logic                is_get;
    logic                is_put;
    logic                get_ok;
    logic                put_ok;
    logic                beat_done;

    assign a_ready_o = !d_valid_o;           // one request in flight
    assign accept = a_valid_i && a_ready_o;
    assign a_idx = a_i.address[BEAT_SIZE +: SRAM_AW];
    assign is_get = (a_i.opcode == OP_GET);
    assign is_put = (a_i.opcode == OP_PUT_FULL) || (a_i.opcode == OP_PUT_PARTIAL);
    assign get_ok = is_get && (a_i.size <= MAX_GET_SIZE);
    assign put_ok = is_put && (a_i.size <= BEAT_SIZE);
    assign beat_done = d_valid_o && d_ready_i;

    always_ff @(posedge tilelink_clock_i) begin
        if (accept && put_ok) begin
            for (int b = 0; b < TL_MW; b++) begin
                if (a_i.mask[b]) begin
                    mem[a_idx][8*b +: 8] <= a_i.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge tilelink_clock_i) begin
        if (tilelink_reset_i) begin
            d_valid_o <= 1'b0;
            beats_left_q <= '0;
        end else if (accept) begin
            d_valid_o <= 1'b1;
            beats_left_q <= get_ok ? burst_beats(a_i.size) : '0;
        end else if (beat_done) begin
            if (beats_left_q == '0) begin
                d_valid_o <= 1'b0;           // last beat taken
            end else begin
                beats_left_q <= beats_left_q - 1'b1;
            end
        end
    end

    always_ff @(posedge tilelink_clock_i) begin
        if (accept) begin
            d_o.opcode <= is_get ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK;
            d_o.param <= '0;
            d_o.size <= a_i.size;
            d_o.source <= a_i.source;
            d_o.denied <= !(get_ok || put_ok);
            d_o.data <= get_ok ? mem[a_idx] : '0;
            d_o.corrupt <= is_get && !get_ok;  // denied data is never valid
            next_idx_q <= a_idx + 1'b1;
        end else if (beat_done && (beats_left_q != '0)) begin
            d_o.data <= mem[next_idx_q];
            next_idx_q <= next_idx_q + 1'b1;
        end
    end

endmodule

//--- logic/tl_subsystem_top.sv
`timescale 1ns/100ps

module tl_subsystem_top
    import tl_pkg::*;
(
    input  logic       tilelink_clock_i,
    input  logic       tilelink_reset_i,

    input  tl_a_chan_t master_a_i,
    input  logic       master_a_valid_i,
    output logic       master_a_ready_o,

    output tl_d_chan_t master_d_o,
    output logic       master_d_valid_o,
    input  logic       master_d_ready_i
);

    tl_a_chan_t                   work_a;
    logic                         work_valid;
    logic                         work_stall;

    tl_a_chan_t [SLAVE_COUNT-1:0] slave_a;
    logic       [SLAVE_COUNT-1:0] slave_a_valid;
    logic       [SLAVE_COUNT-1:0] slave_a_ready;

    tl_d_chan_t [SLAVE_COUNT-1:0] slave_d;
    logic       [SLAVE_COUNT-1:0] slave_d_valid;
    logic       [SLAVE_COUNT-1:0] slave_d_ready;

    tl_skid_buffer i_tl_skid_buffer (
        .tilelink_clock_i (tilelink_clock_i),
        .tilelink_reset_i (tilelink_reset_i),
        .in_i             (master_a_i),
        .in_valid_i       (master_a_valid_i),
        .in_ready_o       (master_a_ready_o),
        .out_o            (work_a),
        .out_valid_o      (work_valid),
        .stall_i          (work_stall)
    );

    tl_request_router i_tl_request_router (
        .tilelink_clock_i (tilelink_clock_i),
        .tilelink_reset_i (tilelink_reset_i),
        .req_i            (work_a),
        .req_valid_i      (work_valid),
        .stall_o          (work_stall),
        .slave_a_o        (slave_a),
        .slave_a_valid_o  (slave_a_valid),
        .slave_a_ready_i  (slave_a_ready)
    );

    for (genvar i = 0; i < SLAVE_COUNT; i++) begin : g_slave
        tl_sram_slave i_tl_sram_slave (
            .tilelink_clock_i (tilelink_clock_i),
            .tilelink_reset_i (tilelink_reset_i),
            .a_i              (slave_a[i]),
            .a_valid_i        (slave_a_valid[i]),
            .a_ready_o        (slave_a_ready[i]),
            .d_o              (slave_d[i]),
            .d_valid_o        (slave_d_valid[i]),
            .d_ready_i        (slave_d_ready[i])
        );
    end

    tl_response_arbiter i_tl_response_arbiter (
        .tilelink_clock_i (tilelink_clock_i),
        .tilelink_reset_i (tilelink_reset_i),
        .slave_d_i        (slave_d),
        .slave_d_valid_i  (slave_d_valid),
        .slave_d_ready_o  (slave_d_ready),
        .master_d_o       (master_d_o),
        .master_d_valid_o (master_d_valid_o),
        .master_d_ready_i (master_d_ready_i)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tl_subsystem_tb -f tb.f

sim_output=$(./obj_dir/Vtl_subsystem_tb) || true
echo "$sim_output"

if echo "$sim_output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- tb.f
logic/tl_pkg.sv
logic/tl_skid_buffer.sv
logic/tl_request_router.sv
logic/tl_response_arbiter.sv
logic/tl_sram_slave.sv
logic/tl_subsystem_top.sv
verification/tl_subsystem_assert.sv
verification/tl_subsystem_tb.sv

//--- verification/tl_subsystem_assert.sv
`timescale 1ns/100ps

module tl_subsystem_assert
    import tl_pkg::*;
(
    input logic                   tilelink_clock_i,
    input logic                   tilelink_reset_i,
    input tl_d_chan_t             master_d_i,
    input logic                   master_d_valid_i,
    input logic                   master_d_ready_i,
    input logic [SLAVE_COUNT-1:0] slave_a_valid_i
);

    d_hold_a: assert property (
        @(posedge tilelink_clock_i) disable iff (tilelink_reset_i)
        master_d_valid_i && !master_d_ready_i |=> master_d_valid_i && $stable(master_d_i)
    ) else $error("master D beat dropped or changed while stalled");

    a_onehot_a: assert property (
        @(posedge tilelink_clock_i) disable iff (tilelink_reset_i)
        $onehot0(slave_a_valid_i)
    ) else $error("more than one target A valid at once");

    reset_quiet_a: assert property (
        @(posedge tilelink_clock_i)
        tilelink_reset_i |=> !master_d_valid_i
    ) else $error("master D valid while in reset");

endmodule

bind tl_response_arbiter tl_subsystem_assert i_d_channel_assert (
    .tilelink_clock_i (tilelink_clock_i),
    .tilelink_reset_i (tilelink_reset_i),
    .master_d_i       (master_d_o),
    .master_d_valid_i (master_d_valid_o),
    .master_d_ready_i (master_d_ready_i),
    .slave_a_valid_i  ('0)                 // A side checked in router instance
);

bind tl_request_router tl_subsystem_assert i_router_assert (
    .tilelink_clock_i (tilelink_clock_i),
    .tilelink_reset_i (tilelink_reset_i),
    .master_d_i       ('0),
    .master_d_valid_i (1'b0),
    .master_d_ready_i (1'b1),
    .slave_a_valid_i  (slave_a_valid_o)
);

//--- verification/tl_subsystem_tb.sv
`timescale 1ns/100ps

module tl_subsystem_tb
    import tl_pkg::*;
();

    localparam int ROWS = 16;
    localparam int A_TIMEOUT = 200;
    localparam int D_TIMEOUT = 400;
    localparam int FILL_WORDS = 8;

    typedef struct packed {
        logic [2:0]  opcode;
        logic [3:0]  size;
        logic [3:0]  source;
        logic [31:0] address;
        logic [3:0]  mask;
        logic [31:0] data;
        logic        random_ready;
        logic        chain;                    // next row goes out without waiting
    } stim_row_t;

    typedef struct packed {
        logic [2:0]  opcode;
        logic [3:0]  size;
        logic [3:0]  source;
        logic        denied;
        logic        corrupt;
        logic [31:0] data;
        logic        check_data;
        logic        last;
    } beat_t;

    logic       tilelink_clock;
    logic       tilelink_reset;
    tl_a_chan_t master_a;
    logic       master_a_valid;
    logic       master_a_ready;
    tl_d_chan_t master_d;
    logic       master_d_valid;
    logic       master_d_ready;

    stim_row_t   table_rows [ROWS];
    logic [31:0] model_mem [2][256];
    beat_t       exp_q [$];
    integer      seed;
    logic        random_ready;
    logic        run_done = 1'b0;
    logic        in_burst;
    logic [3:0]  burst_source;
    int          mismatches;
    int          other_errors;

    tl_subsystem_top i_tl_subsystem_top (
        .tilelink_clock_i (tilelink_clock),
        .tilelink_reset_i (tilelink_reset),
        .master_a_i       (master_a),
        .master_a_valid_i (master_a_valid),
        .master_a_ready_o (master_a_ready),
        .master_d_o       (master_d),
        .master_d_valid_o (master_d_valid),
        .master_d_ready_i (master_d_ready)
    );

    always #4 tilelink_clock = !tilelink_clock;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
            mismatches++;
        end
    endtask

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr;
    endfunction

    function automatic void load_table();
        // opcode, size, source, address, mask, data, random ready, chain
        table_rows[0]  = '{OP_PUT_FULL, 4'd2, 4'd1, 32'h1000, 4'hf, 32'ha5a5_0001, 1'b0, 1'b0};
        table_rows[1]  = '{OP_PUT_FULL, 4'd2, 4'd2, 32'h2004, 4'hf, 32'h5a5a_0002, 1'b0, 1'b0};
        table_rows[2]  = '{OP_GET, 4'd2, 4'd3, 32'h1000, 4'hf, 32'h0, 1'b0, 1'b0};
        table_rows[3]  = '{OP_GET, 4'd2, 4'd4, 32'h2004, 4'hf, 32'h0, 1'b0, 1'b0};
        table_rows[4]  = '{OP_PUT_PARTIAL, 4'd2, 4'd5, 32'h1008, 4'h5, 32'h1122_3344, 1'b0, 1'b0};
        table_rows[5]  = '{OP_GET, 4'd2, 4'd6, 32'h1008, 4'hf, 32'h0, 1'b0, 1'b0};
        table_rows[6]  = '{OP_PUT_PARTIAL, 4'd1, 4'd7, 32'h200e, 4'hc, 32'hbeef_0000, 1'b0, 1'b0};
        table_rows[7]  = '{OP_GET, 4'd2, 4'd8, 32'h200c, 4'hf, 32'h0, 1'b0, 1'b0};
        table_rows[8]  = '{OP_GET, 4'd4, 4'd9, 32'h1000, 4'hf, 32'h0, 1'b0, 1'b0};
        table_rows[9]  = '{OP_GET, 4'd5, 4'd10, 32'h1000, 4'hf, 32'h0, 1'b0, 1'b0};
        table_rows[10] = '{OP_PUT_FULL, 4'd3, 4'd11, 32'h2000, 4'hf, 32'hdead_beef, 1'b0, 1'b0};
        table_rows[11] = '{OP_GET, 4'd4, 4'd12, 32'h2010, 4'hf, 32'h0, 1'b1, 1'b1};
        table_rows[12] = '{OP_GET, 4'd4, 4'd13, 32'h1010, 4'hf, 32'h0, 1'b1, 1'b1};
        table_rows[13] = '{OP_GET, 4'd2, 4'd14, 32'h2000, 4'hf, 32'h0, 1'b1, 1'b1};
        table_rows[14] = '{OP_GET, 4'd3, 4'd15, 32'h1018, 4'hf, 32'h0, 1'b1, 1'b0};
        table_rows[15] = '{OP_GET, 4'd4, 4'd1, 32'h2000, 4'hf, 32'h0, 1'b1, 1'b0};
    endfunction

    // updates the model and queues the beats the request should produce
    function automatic void predict_response(input stim_row_t row);
        int    target;
        int    idx;
        int    beats;
        beat_t b;
        target = (row.address >= 32'h2000) ? 1 : 0;
        idx = int'(row.address[9:2]);
        b = '0;
        b.size = row.size;
        b.source = row.source;
        b.last = 1'b1;
        if (row.opcode == OP_GET) begin
            b.opcode = OP_ACCESS_ACK_DATA;
            if (row.size > 4) begin
                b.denied = 1'b1;
                b.corrupt = 1'b1;              // denied data beat is marked corrupt
                exp_q.push_back(b);
            end else begin
                beats = (row.size > 2) ? (1 << (row.size - 2)) : 1;
                for (int n = 0; n < beats; n++) begin
                    b.data = model_mem[target][(idx + n) % 256];
                    b.check_data = 1'b1;
                    b.last = (n == beats - 1);
                    exp_q.push_back(b);
                end
            end
        end else begin
            b.opcode = OP_ACCESS_ACK;
            b.denied = (row.size > 2);
            for (int k = 0; k < 4; k++) begin
                if (!b.denied && row.mask[k]) begin
                    model_mem[target][idx][8*k +: 8] = row.data[8*k +: 8];
                end
            end
            exp_q.push_back(b);
        end
    endfunction

    task automatic issue_row(input stim_row_t row, output logic ok);
        int cycles;
        ok = 1'b0;
        random_ready = row.random_ready;
        predict_response(row);
        master_a = '0;
        master_a.opcode = row.opcode;
        master_a.size = row.size;
        master_a.source = row.source;
        master_a.address = row.address;
        master_a.mask = row.mask;
        master_a.data = row.data;
        master_a_valid = 1'b1;
        cycles = 0;
        @(negedge tilelink_clock);
        while (!master_a_ready && cycles < A_TIMEOUT) begin
            @(negedge tilelink_clock);
            cycles++;
        end
        if (!master_a_ready) begin
            $display("ERROR at %0t: master A not ready within %0d cycles", $time, A_TIMEOUT);
            other_errors++;
            master_a_valid = 1'b0;
            return;
        end
        @(posedge tilelink_clock);
        #1;
        master_a_valid = 1'b0;
        ok = 1'b1;
        if (!row.chain) begin
            cycles = 0;
            while (exp_q.size() != 0 && cycles < D_TIMEOUT) begin
                @(posedge tilelink_clock);
                #1;
                cycles++;
            end
            if (exp_q.size() != 0) begin
                $display("ERROR at %0t: %0d response beats never arrived", $time, exp_q.size());
                other_errors++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic take_beat();
        int    hit;
        beat_t want;
        hit = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (hit < 0 && exp_q[i].source == master_d.source) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            $display("ERROR at %0t: unexpected D beat from source %0d", $time, master_d.source);
            other_errors++;
            return;
        end
        want = exp_q[hit];
        exp_q.delete(hit);
        if (in_burst && master_d.source != burst_source) begin
            $display("ERROR at %0t: burst of source %0d interleaved with source %0d",
                     $time, burst_source, master_d.source);
            other_errors++;
        end
        in_burst = !want.last;
        burst_source = master_d.source;
        compare_value("master_d_o.opcode", master_d.opcode, want.opcode);
        compare_value("master_d_o.param", master_d.param, 32'd0);
        compare_value("master_d_o.size", master_d.size, want.size);
        compare_value("master_d_o.denied", master_d.denied, want.denied);
        compare_value("master_d_o.corrupt", master_d.corrupt, want.corrupt);
        if (want.check_data) begin
            compare_value("master_d_o.data", master_d.data, want.data);
        end
    endtask

    // D monitor with the ready pattern of the row in flight
    initial begin : collect
        while (!run_done) begin
            @(posedge tilelink_clock);
            #1;
            master_d_ready = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge tilelink_clock);
            if (master_d_valid && master_d_ready) begin
                take_beat();
            end
        end
    end

    initial begin : run
        logic      ok;
        stim_row_t fill;
        seed = 29;
        tilelink_clock = 1'b0;
        tilelink_reset = 1'b1;
        master_a = '0;
        master_a_valid = 1'b0;
        master_d_ready = 1'b1;
        random_ready = 1'b0;
        in_burst = 1'b0;
        burst_source = '0;
        mismatches = 0;
        other_errors = 0;
        ok = 1'b1;
        load_table();
        repeat (10) @(posedge tilelink_clock);
        #1;
        tilelink_reset = 1'b0;
        @(negedge tilelink_clock);
        compare_value("master_d_valid_o", master_d_valid, 32'd0);
        compare_value("master_a_ready_o", master_a_ready, 32'd1);
        @(posedge tilelink_clock);
        #1;
        for (int w = 0; w < 2 * FILL_WORDS && ok; w++) begin
            fill.address = 32'h1000 * (1 + w / FILL_WORDS) + 4 * (w % FILL_WORDS);
            fill = '{OP_PUT_FULL, 4'd2, 4'd0, fill.address, 4'hf, fill_pattern(fill.address),
                     1'b0, 1'b0};
            issue_row(fill, ok);
        end
        for (int r = 0; r < ROWS && ok; r++) begin
            issue_row(table_rows[r], ok);
        end
        run_done = 1'b1;
        if (ok && exp_q.size() != 0) begin
            $display("ERROR at %0t: %0d expected beats left over", $time, exp_q.size());
            other_errors++;
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
